// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_ldst_top
FILELIST := all.f
OBJ_DIR  := obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
hdl/ldst_pkg.sv
hdl/mem_ifs.sv
hdl/byte_selector.sv
hdl/load_unit.sv
hdl/store_unit.sv
hdl/mem_arbiter.sv
hdl/data_mem.sv
hdl/ldst_top.sv
verif/tb_ldst_top.sv

// ==== hdl/byte_selector.sv ====
// Byte selector
// Picks the byte, halfword or word at the offset of a doubleword line
// and sign-extends or zero-pads it to the full data width
`default_nettype none

module byte_selector import ldst_pkg::*; (
    input  ldst_type_t type_i,
    input  byte_off_t  byte_off_i,
    input  line_t      line_i,
    output line_t      line_o
);

    logic [4*BYTE_W-1:0] sel_w;
    logic [2*BYTE_W-1:0] sel_h;
    logic [BYTE_W-1:0]   sel_b;

    // One mux level per offset bit, from the widest chunk down
    always_comb begin
        // Upper or lower word
        sel_w = byte_off_i[2] ? line_i[8*BYTE_W-1 -: 4*BYTE_W] : line_i[4*BYTE_W-1 -: 4*BYTE_W];
        // Upper or lower halfword of that word
        sel_h = byte_off_i[1] ? sel_w[4*BYTE_W-1 -: 2*BYTE_W] : sel_w[2*BYTE_W-1 -: 2*BYTE_W];
        // Upper or lower byte of that halfword
        sel_b = byte_off_i[0] ? sel_h[2*BYTE_W-1 -: BYTE_W] : sel_h[BYTE_W-1 -: BYTE_W];
    end

    // Extension by access type
    always_comb begin
        case (type_i)
            LS_BYTE:       line_o = {{(XLEN-BYTE_W){sel_b[BYTE_W-1]}}, sel_b};
            LS_BYTE_U:     line_o = {{(XLEN-BYTE_W){1'b0}}, sel_b};
            LS_HALFWORD:   line_o = {{(XLEN-2*BYTE_W){sel_h[2*BYTE_W-1]}}, sel_h};
            LS_HALFWORD_U: line_o = {{(XLEN-2*BYTE_W){1'b0}}, sel_h};
            LS_WORD:       line_o = {{(XLEN-4*BYTE_W){sel_w[4*BYTE_W-1]}}, sel_w};
            LS_WORD_U:     line_o = {{(XLEN-4*BYTE_W){1'b0}}, sel_w};
            // Whole line passes through
            default:       line_o = line_i;
        endcase
    end

    // Misaligned offsets must be refused upstream, never selected here
    always_comb begin
        case (type_i)
            LS_HALFWORD, LS_HALFWORD_U: begin
                assert (!byte_off_i[0])
                else $warning("%s with misaligned byte offset %b", type_i.name(), byte_off_i);
            end
            LS_WORD, LS_WORD_U: begin
                assert (byte_off_i[1:0] == 2'b00)
                else $warning("%s with misaligned byte offset %b", type_i.name(), byte_off_i);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/data_mem.sv ====
// Data memory
// Synchronous doubleword RAM, byte-enable writes, read line
// registered and valid one cycle after the access
`default_nettype none

module data_mem import ldst_pkg::*; #(
    parameter int ADDR_W = 10
) (
    input  wire     clk_i,
    mem_bus_if.mem  bus
);

    localparam int DEPTH = 2 ** (ADDR_W - 3);

    line_t mem_q [DEPTH];
    line_t rdata_q;

    // Contents undefined until written
    always_ff @(posedge clk_i) begin
        if (bus.en) begin
            if (bus.we) begin
                // Only enabled bytes change
                for (int b = 0; b < LINE_BYTES; b++) begin
                    if (bus.be[b]) begin
                        mem_q[bus.addr][b*BYTE_W +: BYTE_W] <= bus.wdata[b*BYTE_W +: BYTE_W];
                    end
                end
            end else begin
                rdata_q <= mem_q[bus.addr];
            end
        end
    end

    assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== hdl/ldst_pkg.sv ====
// Load/store package
// Shared widths, access type encoding and alignment rule for the
// doubleword data-memory path of the 64-bit core
`default_nettype none

package ldst_pkg;

    // Data width, fixed by the three-level byte selector
    localparam int XLEN      = 64;
    localparam int BYTE_W    = 8;
    localparam int LINE_BYTES = XLEN / BYTE_W;

    // Doubleword line, byte offset within it and one enable per byte
    typedef logic [XLEN-1:0]       line_t;
    typedef logic [2:0]            byte_off_t;
    typedef logic [LINE_BYTES-1:0] be_t;

    // Access size and signedness, stores ignore the signedness
    typedef enum logic [2:0] {
        LS_BYTE       = 3'd0,
        LS_BYTE_U     = 3'd1,
        LS_HALFWORD   = 3'd2,
        LS_HALFWORD_U = 3'd3,
        LS_WORD       = 3'd4,
        LS_WORD_U     = 3'd5,
        LS_DOUBLEWORD = 3'd6
    } ldst_type_t;

    // Offset bits below the access size, these must be zero
    localparam byte_off_t ALIGN_MASK_B = 3'b000;
    localparam byte_off_t ALIGN_MASK_H = 3'b001;
    localparam byte_off_t ALIGN_MASK_W = 3'b011;
    localparam byte_off_t ALIGN_MASK_D = 3'b111;

    // Alignment mask for a given access type
    function automatic byte_off_t ls_align_mask(input ldst_type_t t);
        case (t)
            LS_BYTE, LS_BYTE_U:         return ALIGN_MASK_B;
            LS_HALFWORD, LS_HALFWORD_U: return ALIGN_MASK_H;
            LS_WORD, LS_WORD_U:         return ALIGN_MASK_W;
            default:                    return ALIGN_MASK_D;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== hdl/ldst_top.sv ====
// Load/store top level
// Load and store units share one data memory through the
// round-robin arbiter, plain ports on the outside
`default_nettype none

module ldst_top import ldst_pkg::*; #(
    parameter int ADDR_W = 10
) (
    input  wire               clk_i,
    input  wire               arst_n_i,
    // Load side
    input  wire               ld_req_i,
    input  ldst_type_t        ld_type_i,
    input  wire  [ADDR_W-1:0] ld_addr_i,
    output logic              ld_busy_o,
    output logic              ld_done_o,
    output logic              ld_err_o,
    output line_t             ld_data_o,
    // Store side
    input  wire               st_req_i,
    input  ldst_type_t        st_type_i,
    input  wire  [ADDR_W-1:0] st_addr_i,
    input  line_t             st_data_i,
    output logic              st_busy_o,
    output logic              st_done_o,
    output logic              st_err_o
);

    mem_port_if #(.ADDR_W(ADDR_W)) ld_port ();
    mem_port_if #(.ADDR_W(ADDR_W)) st_port ();
    mem_bus_if  #(.ADDR_W(ADDR_W)) bus ();

    load_unit #(.ADDR_W(ADDR_W)) i_load_unit (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (ld_req_i),
        .type_i   (ld_type_i),
        .addr_i   (ld_addr_i),
        .busy_o   (ld_busy_o),
        .done_o   (ld_done_o),
        .err_o    (ld_err_o),
        .data_o   (ld_data_o),
        .port     (ld_port.unit)
    );

    store_unit #(.ADDR_W(ADDR_W)) i_store_unit (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (st_req_i),
        .type_i   (st_type_i),
        .addr_i   (st_addr_i),
        .data_i   (st_data_i),
        .busy_o   (st_busy_o),
        .done_o   (st_done_o),
        .err_o    (st_err_o),
        .port     (st_port.unit)
    );

    mem_arbiter #(.ADDR_W(ADDR_W)) i_mem_arbiter (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .ld_port  (ld_port.arb),
        .st_port  (st_port.arb),
        .bus      (bus.ctrl)
    );

    data_mem #(.ADDR_W(ADDR_W)) i_data_mem (
        .clk_i (clk_i),
        .bus   (bus.mem)
    );

endmodule

`default_nettype wire

// ==== hdl/load_unit.sv ====
// Load unit
// Takes one load request at a time, refuses misaligned offsets,
// reads the line through the arbiter and returns the extended value
`default_nettype none

module load_unit import ldst_pkg::*; #(
    parameter int ADDR_W = 10
) (
    input  wire               clk_i,
    input  wire               arst_n_i,
    input  wire               req_i,
    input  ldst_type_t        type_i,
    input  wire  [ADDR_W-1:0] addr_i,
    output logic              busy_o,
    output logic              done_o,
    output logic              err_o,
    output line_t             data_o,
    mem_port_if.unit          port
);

    typedef enum logic [1:0] {IDLE, REQ, WAIT} ld_state_t;

    ld_state_t         state_q;
    logic              strobe;
    logic              misaligned;
    logic              err_q;
    ldst_type_t        type_q;
    byte_off_t         off_q;
    logic [ADDR_W-4:0] idx_q;
    line_t             sel_line;
    line_t             data_q;

    // Strobe only counts while idle
    assign strobe     = req_i && (state_q == IDLE);
    assign misaligned = |(addr_i[2:0] & ls_align_mask(type_i));

    // Control FSM
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            err_q   <= 1'b0;
        end else begin
            // Refused request, one-cycle error with done
            err_q <= strobe && misaligned;
            case (state_q)
                IDLE: if (strobe && !misaligned) state_q <= REQ;
                REQ:  if (port.gnt) state_q <= WAIT;
                WAIT: state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // Request fields, captured only for accepted loads
    always_ff @(posedge clk_i) begin
        if (strobe && !misaligned) begin
            type_q <= type_i;
            off_q  <= addr_i[2:0];
            idx_q  <= addr_i[ADDR_W-1:3];
        end
        if (state_q == WAIT) data_q <= sel_line;
    end

    // Read the whole line, no write
    assign port.req   = (state_q == REQ);
    assign port.we    = 1'b0;
    assign port.addr  = idx_q;
    assign port.wdata = '0;
    assign port.be    = '1;

    byte_selector i_byte_selector (
        .type_i     (type_q),
        .byte_off_i (off_q),
        .line_i     (port.rdata),
        .line_o     (sel_line)
    );

    // Result shows in the done cycle, then is held
    assign data_o = (state_q == WAIT) ? sel_line : data_q;
    assign busy_o = (state_q != IDLE);
    assign done_o = err_q || (state_q == WAIT);
    assign err_o  = err_q;

    a_no_req_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (state_q == IDLE) |-> !port.req);

endmodule

`default_nettype wire

// ==== hdl/mem_arbiter.sv ====
// Round-robin memory arbiter
// Grants the load or store port, at most one per cycle, drives the
// memory bus from the winner and returns read data to it
`default_nettype none

module mem_arbiter import ldst_pkg::*; #(
    parameter int ADDR_W = 10
) (
    input  wire      clk_i,
    input  wire      arst_n_i,
    mem_port_if.arb  ld_port,
    mem_port_if.arb  st_port,
    mem_bus_if.ctrl  bus
);

    logic prio_st_q;  // Set when the store port is favored
    logic ld_gnt;
    logic st_gnt;
    logic rd_ld_q;
    logic rd_st_q;
    logic contest;

    assign contest = ld_port.req && st_port.req;

    // Load wins unless the store is favored and also requesting
    assign ld_gnt = ld_port.req && (!st_port.req || !prio_st_q);
    assign st_gnt = st_port.req && !ld_gnt;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prio_st_q <= 1'b0;
            rd_ld_q   <= 1'b0;
            rd_st_q   <= 1'b0;
        end else begin
            // Pointer moves only on contention, to the port that lost
            if (contest) prio_st_q <= ld_gnt;
            // Remember who owns next cycle's read data
            rd_ld_q <= ld_gnt && !ld_port.we;
            rd_st_q <= st_gnt && !st_port.we;
        end
    end

    assign ld_port.gnt = ld_gnt;
    assign st_port.gnt = st_gnt;

    // Bus fields from the winner
    assign bus.en    = ld_gnt || st_gnt;
    assign bus.we    = st_gnt ? st_port.we    : ld_port.we;
    assign bus.addr  = st_gnt ? st_port.addr  : ld_port.addr;
    assign bus.wdata = st_gnt ? st_port.wdata : ld_port.wdata;
    assign bus.be    = st_gnt ? st_port.be    : ld_port.be;

    // Read line goes back only to its owner
    assign ld_port.rdata = rd_ld_q ? bus.rdata : '0;
    assign st_port.rdata = rd_st_q ? bus.rdata : '0;

    a_one_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(ld_port.gnt && st_port.gnt));

    // The losing unit holds its request and is served next cycle
    a_loser_next: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        contest |=> (ld_port.gnt || st_port.gnt));

endmodule

`default_nettype wire

// ==== hdl/mem_ifs.sv ====
// Memory interfaces
// mem_port_if joins a load or store unit to the arbiter,
// mem_bus_if joins the arbiter to the data memory
`default_nettype none

interface mem_port_if import ldst_pkg::*; #(parameter int ADDR_W = 10) ();
    logic              req;
    logic              we;
    logic [ADDR_W-4:0] addr;   // Line index, byte address without its low 3 bits
    line_t             wdata;
    be_t               be;
    logic              gnt;    // One-cycle grant pulse
    line_t             rdata;  // Valid the cycle after gnt

    modport unit (output req, we, addr, wdata, be, input gnt, rdata);
    modport arb  (input req, we, addr, wdata, be, output gnt, rdata);
endinterface

interface mem_bus_if import ldst_pkg::*; #(parameter int ADDR_W = 10) ();
    logic              en;
    logic              we;
    logic [ADDR_W-4:0] addr;
    line_t             wdata;
    be_t               be;
    line_t             rdata;

    modport ctrl (output en, we, addr, wdata, be, input rdata);
    modport mem  (input en, we, addr, wdata, be, output rdata);
endinterface

`default_nettype wire

// ==== hdl/store_unit.sv ====
// Store unit
// Takes one store request at a time, refuses misaligned offsets,
// builds byte enables and the shifted line, and writes through the arbiter
`default_nettype none

module store_unit import ldst_pkg::*; #(
    parameter int ADDR_W = 10
) (
    input  wire               clk_i,
    input  wire               arst_n_i,
    input  wire               req_i,
    input  ldst_type_t        type_i,
    input  wire  [ADDR_W-1:0] addr_i,
    input  line_t             data_i,
    output logic              busy_o,
    output logic              done_o,
    output logic              err_o,
    mem_port_if.unit          port
);

    typedef enum logic [1:0] {IDLE, REQ, DONE} st_state_t;

    st_state_t         state_q;
    logic              strobe;
    logic              misaligned;
    logic              err_q;
    be_t               size_be;
    be_t               be_q;
    line_t             wline_q;
    logic [ADDR_W-4:0] idx_q;

    assign strobe     = req_i && (state_q == IDLE);
    assign misaligned = |(addr_i[2:0] & ls_align_mask(type_i));

    // Enables for the access size, before shifting to the offset
    always_comb begin
        case (type_i)
            LS_BYTE, LS_BYTE_U:         size_be = 8'h01;
            LS_HALFWORD, LS_HALFWORD_U: size_be = 8'h03;
            LS_WORD, LS_WORD_U:         size_be = 8'h0f;
            default:                    size_be = 8'hff;
        endcase
    end

    // Control FSM
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            err_q   <= 1'b0;
        end else begin
            err_q <= strobe && misaligned;
            case (state_q)
                IDLE: if (strobe && !misaligned) state_q <= REQ;
                // Hold the request until granted
                REQ:  if (port.gnt) state_q <= DONE;
                DONE: state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // Low bytes of the data move up to the offset position
    always_ff @(posedge clk_i) begin
        if (strobe && !misaligned) begin
            be_q    <= size_be << addr_i[2:0];
            wline_q <= data_i << {addr_i[2:0], 3'b000};
            idx_q   <= addr_i[ADDR_W-1:3];
        end
    end

    assign port.req   = (state_q == REQ);
    assign port.we    = 1'b1;
    assign port.addr  = idx_q;
    assign port.wdata = wline_q;
    assign port.be    = be_q;

    assign busy_o = (state_q != IDLE);
    assign done_o = err_q || (state_q == DONE);
    assign err_o  = err_q;

    // A write request always carries at least one byte
    a_be_nonzero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        port.req |-> (port.be != '0));

endmodule

`default_nettype wire

// ==== verif/tb_ldst_top.sv ====
// Load/store path testbench
// Directed tests of the load and store units sharing the data memory,
// checked against a byte-wide model of the memory contents
`default_nettype none

module tb_ldst_top import ldst_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_W  = 10;
    localparam int TIMEOUT = 20;

    typedef logic [ADDR_W-1:0] addr_t;

    logic       clk;
    logic       arst_n;
    logic       ld_req;
    ldst_type_t ld_type;
    addr_t      ld_addr;
    logic       ld_busy;
    logic       ld_done;
    logic       ld_err;
    line_t      ld_data;
    logic       st_req;
    ldst_type_t st_type;
    addr_t      st_addr;
    line_t      st_data;
    logic       st_busy;
    logic       st_done;
    logic       st_err;

    // Byte-wide reference copy of the data memory
    logic [7:0] model_mem [0:(1<<ADDR_W)-1];
    integer     seed;
    int         errors;
    int         checks;
    int         tests_run;
    int         test_errors;

    ldst_top #(.ADDR_W(ADDR_W)) i_dut (
        .clk_i     (clk),
        .arst_n_i  (arst_n),
        .ld_req_i  (ld_req),
        .ld_type_i (ld_type),
        .ld_addr_i (ld_addr),
        .ld_busy_o (ld_busy),
        .ld_done_o (ld_done),
        .ld_err_o  (ld_err),
        .ld_data_o (ld_data),
        .st_req_i  (st_req),
        .st_type_i (st_type),
        .st_addr_i (st_addr),
        .st_data_i (st_data),
        .st_busy_o (st_busy),
        .st_done_o (st_done),
        .st_err_o  (st_err)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int size_bytes(input ldst_type_t t);
        case (t)
            LS_BYTE, LS_BYTE_U:         return 1;
            LS_HALFWORD, LS_HALFWORD_U: return 2;
            LS_WORD, LS_WORD_U:         return 4;
            default:                    return 8;
        endcase
    endfunction

    // Gather the bytes little-endian, then extend from the top byte
    function automatic line_t expect_load(input ldst_type_t t, input addr_t a);
        int    n;
        line_t v;
        logic  sgn;
        n = size_bytes(t);
        v = '0;
        for (int i = 0; i < n; i++) v[8*i +: 8] = model_mem[int'(a) + i];
        sgn = v[8*n-1];
        if (t == LS_BYTE || t == LS_HALFWORD || t == LS_WORD) begin
            for (int i = n; i < 8; i++) v[8*i +: 8] = {8{sgn}};
        end
        return v;
    endfunction

    task automatic model_store(input ldst_type_t t, input addr_t a, input line_t d);
        for (int i = 0; i < size_bytes(t); i++) model_mem[int'(a) + i] = d[8*i +: 8];
    endtask

    task automatic check_value(input string name, input line_t exp, input line_t got);
        checks++;
        if (got !== exp) begin
            $display("error at %0t: %s expected %0h got %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("%-20s %s, %0d errors", name, (errors == test_errors) ? "ok" : "FAILED",
                 errors - test_errors);
        test_errors = errors;
    endtask

    // One load strobe, then wait for done
    task automatic load_op(input ldst_type_t t, input addr_t a, output line_t data,
                           output logic err, output logic busy_seen);
        logic seen;
        seen      = 1'b0;
        busy_seen = 1'b0;
        err       = 1'b0;
        data      = '0;
        @(negedge clk);
        ld_type = t;
        ld_addr = a;
        ld_req  = 1'b1;
        for (int i = 0; i < TIMEOUT && !seen; i++) begin
            @(negedge clk);
            ld_req    = 1'b0;
            busy_seen = busy_seen | ld_busy;
            if (ld_done) begin
                seen = 1'b1;
                data = ld_data;
                err  = ld_err;
            end
        end
        if (!seen) begin
            $display("load %s at %0h never signaled done", t.name(), a);
            errors++;
        end
    endtask

    // One store strobe, then wait for done
    task automatic store_op(input ldst_type_t t, input addr_t a, input line_t d,
                            output logic err, output logic busy_seen);
        logic seen;
        seen      = 1'b0;
        busy_seen = 1'b0;
        err       = 1'b0;
        @(negedge clk);
        st_type = t;
        st_addr = a;
        st_data = d;
        st_req  = 1'b1;
        for (int i = 0; i < TIMEOUT && !seen; i++) begin
            @(negedge clk);
            st_req    = 1'b0;
            busy_seen = busy_seen | st_busy;
            if (st_done) begin
                seen = 1'b1;
                err  = st_err;
            end
        end
        if (!seen) begin
            $display("store %s at %0h never signaled done", t.name(), a);
            errors++;
        end
    endtask

    task automatic load_and_check(input ldst_type_t t, input addr_t a);
        line_t got;
        logic  err;
        logic  busy;
        load_op(t, a, got, err, busy);
        check_value("ld_err_o", '0, line_t'(err));
        check_value("ld_data_o", expect_load(t, a), got);
    endtask

    task automatic store_and_model(input ldst_type_t t, input addr_t a, input line_t d);
        logic err;
        logic busy;
        store_op(t, a, d, err, busy);
        check_value("st_err_o", '0, line_t'(err));
        model_store(t, a, d);
    endtask

    // Misaligned accesses end with err and done, busy never rises
    task automatic refused_load(input ldst_type_t t, input addr_t a);
        line_t got;
        logic  err;
        logic  busy;
        load_op(t, a, got, err, busy);
        check_value("ld_err_o", line_t'(1), line_t'(err));
        check_value("ld_busy_o", '0, line_t'(busy));
    endtask

    task automatic refused_store(input ldst_type_t t, input addr_t a);
        logic err;
        logic busy;
        store_op(t, a, 64'hdead_beef_dead_beef, err, busy);
        check_value("st_err_o", line_t'(1), line_t'(err));
        check_value("st_busy_o", '0, line_t'(busy));
    endtask

    // Doubleword load and store to one line, strobed together
    task automatic pair_op(input addr_t a, input line_t d, output line_t ld_val,
                           output int ld_cyc, output int st_cyc);
        ld_cyc = 0;
        st_cyc = 0;
        ld_val = '0;
        @(negedge clk);
        ld_type = LS_DOUBLEWORD;
        ld_addr = a;
        ld_req  = 1'b1;
        st_type = LS_DOUBLEWORD;
        st_addr = a;
        st_data = d;
        st_req  = 1'b1;
        for (int i = 1; i <= TIMEOUT && (ld_cyc == 0 || st_cyc == 0); i++) begin
            @(negedge clk);
            ld_req = 1'b0;
            st_req = 1'b0;
            if (ld_done) begin
                ld_cyc = i;
                ld_val = ld_data;
            end
            if (st_done) st_cyc = i;
        end
        if (ld_cyc == 0 || st_cyc == 0) begin
            $display("load and store at %0h did not both finish", a);
            errors++;
        end
    endtask

    task automatic test_reset();
        check_value("ld_busy_o", '0, line_t'(ld_busy));
        check_value("ld_done_o", '0, line_t'(ld_done));
        check_value("ld_err_o", '0, line_t'(ld_err));
        check_value("st_busy_o", '0, line_t'(st_busy));
        check_value("st_done_o", '0, line_t'(st_done));
        check_value("st_err_o", '0, line_t'(st_err));
        finish_test("reset");
    endtask

    // Bytes, halfwords and words with mixed top bits exercise both extensions
    task automatic test_all_types();
        ldst_type_t t;
        store_and_model(LS_DOUBLEWORD, addr_t'('h40), 64'h718c_7a05_e39b_2680);
        for (int k = 0; k < 7; k++) begin
            t = ldst_type_t'(k);
            for (int off = 0; off < 8; off += size_bytes(t)) begin
                load_and_check(t, addr_t'('h40 + off));
            end
        end
        finish_test("all types");
    endtask

    // Upper data bits are junk and must not reach memory
    task automatic test_partial_stores();
        store_and_model(LS_DOUBLEWORD, addr_t'('h80), 64'h0123_4567_89ab_cdef);
        store_and_model(LS_DOUBLEWORD, addr_t'('h88), 64'hfedc_ba98_7654_3210);
        store_and_model(LS_BYTE, addr_t'('h85), 64'h1122_3344_5566_77a8);
        store_and_model(LS_HALFWORD_U, addr_t'('h82), 64'h99aa_bbcc_ddee_5af0);
        store_and_model(LS_WORD, addr_t'('h8c), 64'h7777_6666_c3d2_e1f0);
        load_and_check(LS_DOUBLEWORD, addr_t'('h80));
        load_and_check(LS_DOUBLEWORD, addr_t'('h88));
        finish_test("partial stores");
    endtask

    task automatic test_misaligned();
        refused_load(LS_HALFWORD, addr_t'('h41));
        refused_load(LS_WORD_U, addr_t'('h42));
        refused_load(LS_DOUBLEWORD, addr_t'('h44));
        refused_store(LS_HALFWORD, addr_t'('h43));
        refused_store(LS_WORD, addr_t'('h46));
        refused_store(LS_DOUBLEWORD, addr_t'('h41));
        load_and_check(LS_DOUBLEWORD, addr_t'('h40));
        finish_test("misaligned");
    endtask

    // Load wins the first tie, store wins the next one
    task automatic test_contention();
        line_t got;
        int    lc;
        int    sc;
        store_and_model(LS_DOUBLEWORD, addr_t'('hc0), 64'h5555_aaaa_0f0f_f0f0);
        pair_op(addr_t'('hc0), 64'h1357_9bdf_2468_ace0, got, lc, sc);
        check_value("ld_data_o", 64'h5555_aaaa_0f0f_f0f0, got);
        check_value("ld_done_o cycle", line_t'(2), line_t'(lc));
        check_value("st_done_o cycle", line_t'(3), line_t'(sc));
        model_store(LS_DOUBLEWORD, addr_t'('hc0), 64'h1357_9bdf_2468_ace0);
        pair_op(addr_t'('hc0), 64'h0bad_cafe_f00d_1234, got, lc, sc);
        check_value("ld_data_o", 64'h0bad_cafe_f00d_1234, got);
        check_value("st_done_o cycle", line_t'(2), line_t'(sc));
        check_value("ld_done_o cycle", line_t'(3), line_t'(lc));
        model_store(LS_DOUBLEWORD, addr_t'('hc0), 64'h0bad_cafe_f00d_1234);
        load_and_check(LS_DOUBLEWORD, addr_t'('hc0));
        finish_test("contention");
    endtask

    // Random traffic over eight lines, written in full first
    task automatic test_random();
        ldst_type_t t;
        addr_t      a;
        line_t      d;
        int         off;
        for (int i = 0; i < 8; i++) begin
            d = {$random(seed), $random(seed)};
            store_and_model(LS_DOUBLEWORD, addr_t'('h100 + 8 * i), d);
        end
        for (int n = 0; n < 40; n++) begin
            t   = ldst_type_t'($unsigned($random(seed)) % 7);
            off = int'($unsigned($random(seed)) % 64);
            // Round the offset down to the access size
            a   = addr_t'('h100 + off - (off % size_bytes(t)));
            d   = {$random(seed), $random(seed)};
            if ($random(seed) & 1) store_and_model(t, a, d);
            else load_and_check(t, a);
        end
        finish_test("random");
    endtask

    initial begin
        seed        = 32'h9b6a7a58;
        errors      = 0;
        checks      = 0;
        tests_run   = 0;
        test_errors = 0;
        arst_n      = 1'b0;
        ld_req      = 1'b0;
        ld_type     = LS_BYTE;
        ld_addr     = '0;
        st_req      = 1'b0;
        st_type     = LS_BYTE;
        st_addr     = '0;
        st_data     = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        test_reset();
        test_all_types();
        test_partial_stores();
        test_misaligned();
        test_contention();
        test_random();
        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
